//--- csr_unit_config.svh
//////////////////////////////////////////////////
// CSR unit configuration
// ISA option flags, mtvec reset value and the
// mepc alignment mask that follows from them
//////////////////////////////////////////////////

`ifndef CSR_UNIT_CONFIG_SVH
`define CSR_UNIT_CONFIG_SVH

// ISA options, 0 or 1
`define CSR_ISA_M 1
`define CSR_ISA_C 1
`define CSR_ISA_F 1

// Trap vector base after reset, direct mode
`define CSR_MTVEC_RESET 32'h0000_0100

// Low bits cleared in mepc, 2-byte steps with C
`define CSR_MEPC_ALIGN_MASK ((`CSR_ISA_C != 0) ? 32'hFFFF_FFFE : 32'hFFFF_FFFC)

`endif

//--- csr_pkg.sv
//////////////////////////////////////////////////
// CSR unit package
// Shared widths, CSR addresses, operations and
// the request, write-back and trap structs
//////////////////////////////////////////////////

package csr_pkg;

    // Widths with a meaning of their own
    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [4:0]  exc_cause_t;

    // Operation applied to the addressed CSR
    typedef enum logic [1:0] {
        CSR_READ  = 2'b00,
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_e;

    //////////////////////////////////////////////////
    // CSR addresses
    //////////////////////////////////////////////////

    // User floating point
    localparam csr_addr_t CSR_FFLAGS    = 12'h001;
    localparam csr_addr_t CSR_FRM       = 12'h002;
    localparam csr_addr_t CSR_FCSR      = 12'h003;
    // Machine trap setup
    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MISA      = 12'h301;
    localparam csr_addr_t CSR_MIE       = 12'h304;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;
    // Machine trap handling
    localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MCAUSE    = 12'h342;
    // Machine information, read-only
    localparam csr_addr_t CSR_MVENDORID = 12'hF11;
    localparam csr_addr_t CSR_MARCHID   = 12'hF12;
    localparam csr_addr_t CSR_MIMPID    = 12'hF13;
    localparam csr_addr_t CSR_MHARTID   = 12'hF14;

    // Exception codes
    localparam exc_cause_t EXC_ILLEGAL_INSTR = 5'd2;

    //////////////////////////////////////////////////
    // Stage structs
    //////////////////////////////////////////////////

    // Decoded CSR request, decode to execute
    typedef struct packed {
        logic      valid;
        csr_addr_t addr;
        csr_op_e   op;
        xlen_t     wdata;
        reg_idx_t  rd;
        logic      illegal;
    } csr_req_t;

    // Result towards the register file write port
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        xlen_t    data;
        logic     illegal;
    } csr_wb_t;

    // Trap entry strobe from the core
    typedef struct packed {
        logic       valid;
        xlen_t      pc;
        exc_cause_t cause;
    } trap_req_t;

endpackage

//--- csr_decoder.sv
//////////////////////////////////////////////////
// CSR decoder
// SYSTEM instruction and rs1 value to CSR request,
// with legality from address and read-only rules
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "csr_unit_config.svh"

module csr_decoder (
    input  logic              instr_valid_i,
    input  csr_pkg::xlen_t    instr_i,
    input  csr_pkg::xlen_t    rs1_data_i,
    output csr_pkg::csr_req_t req_o
);

    import csr_pkg::*;

    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

    // Instruction fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_idx_t   rs1_idx;
    csr_addr_t  addr;
    xlen_t      zimm;

    logic       is_csr_form;
    logic       addr_known;
    logic       addr_read_only;
    csr_op_e    op;

    assign opcode  = instr_i[6:0];
    assign funct3  = instr_i[14:12];
    assign rs1_idx = instr_i[19:15];
    assign addr    = instr_i[31:20];
    // Immediate forms reuse the rs1 field
    assign zimm    = {27'b0, instr_i[19:15]};

    // funct3 bit 2 picks immediate, low bits pick the operation
    always_comb begin
        is_csr_form = (opcode == OPCODE_SYSTEM);
        op          = CSR_READ;
        case (funct3[1:0])
            2'b01: op = CSR_WRITE;
            // No source bits means a pure read
            2'b10: op = (rs1_idx == '0) ? CSR_READ : CSR_SET;
            2'b11: op = (rs1_idx == '0) ? CSR_READ : CSR_CLEAR;
            // ECALL, EBREAK, xRET and funct3 100
            default: is_csr_form = 1'b0;
        endcase
    end

    // Implemented addresses
    always_comb begin
        case (addr)
            CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC,
            CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE,
            CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID: begin
                addr_known = 1'b1;
            end
            // FP CSRs only with the F option
            CSR_FFLAGS, CSR_FRM, CSR_FCSR: begin
                addr_known = (`CSR_ISA_F != 0);
            end
            default: begin
                addr_known = 1'b0;
            end
        endcase
    end

    // Top two address bits 11 mark read-only space
    assign addr_read_only = (addr[11:10] == 2'b11);

    // Request out
    always_comb begin
        req_o.valid   = instr_valid_i;
        req_o.addr    = addr;
        req_o.op      = op;
        req_o.wdata   = funct3[2] ? zimm : rs1_data_i;
        req_o.rd      = instr_i[11:7];
        req_o.illegal = !is_csr_form || !addr_known
                        || ((op != CSR_READ) && addr_read_only);
    end

endmodule

//--- csr_regfile.sv
//////////////////////////////////////////////////
// Machine CSR register file
// Read mux, read-modify-write with per-CSR masks,
// trap save and fflags accumulation
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "csr_unit_config.svh"

module csr_regfile (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  csr_pkg::csr_req_t  req_i,
    input  csr_pkg::xlen_t     hartid_i,
    input  csr_pkg::trap_req_t trap_i,
    input  logic               fflags_set_i,
    input  logic [4:0]         fflags_i,
    output csr_pkg::xlen_t     rdata_o,
    output csr_pkg::xlen_t     mtvec_o,
    output csr_pkg::xlen_t     mepc_o,
    output logic [2:0]         frm_o
);

    import csr_pkg::*;

    // MXL 32-bit, I always, M F C from the options
    localparam xlen_t MISA_VALUE = {2'b01, 4'b0, 13'b0, 1'(`CSR_ISA_M), 3'b0, 1'b1,
                                    2'b0, 1'(`CSR_ISA_F), 2'b0, 1'(`CSR_ISA_C), 2'b0};

    // Current state
    logic       mstatus_mie_q;
    logic       mstatus_mpie_q;
    xlen_t      mie_q;
    xlen_t      mtvec_q;
    xlen_t      mepc_q;
    exc_cause_t mcause_q;
    xlen_t      mscratch_q;
    logic [4:0] fflags_q;
    logic [2:0] frm_q;

    // Next state
    logic       mstatus_mie_n;
    logic       mstatus_mpie_n;
    xlen_t      mie_n;
    xlen_t      mtvec_n;
    xlen_t      mepc_n;
    exc_cause_t mcause_n;
    xlen_t      mscratch_n;
    logic [4:0] fflags_n;
    logic [2:0] frm_n;

    logic       wen;
    xlen_t      wval;

    //////////////////////////////////////////////////
    // Read side
    //////////////////////////////////////////////////

    always_comb begin
        case (req_i.addr)
            CSR_MISA:      rdata_o = MISA_VALUE;
            CSR_MVENDORID: rdata_o = '0;
            CSR_MARCHID:   rdata_o = '0;
            CSR_MIMPID:    rdata_o = '0;
            CSR_MHARTID:   rdata_o = hartid_i;
            // MPP fixed at M mode
            CSR_MSTATUS:   rdata_o = {19'b0, 2'b11, 3'b0, mstatus_mpie_q,
                                      3'b0, mstatus_mie_q, 3'b0};
            CSR_MIE:       rdata_o = mie_q;
            CSR_MTVEC:     rdata_o = mtvec_q;
            CSR_MSCRATCH:  rdata_o = mscratch_q;
            CSR_MEPC:      rdata_o = mepc_q;
            // No interrupts, bit 31 stays zero
            CSR_MCAUSE:    rdata_o = {27'b0, mcause_q};
            CSR_FFLAGS:    rdata_o = (`CSR_ISA_F != 0) ? {27'b0, fflags_q} : '0;
            CSR_FRM:       rdata_o = (`CSR_ISA_F != 0) ? {29'b0, frm_q} : '0;
            CSR_FCSR:      rdata_o = (`CSR_ISA_F != 0) ? {24'b0, frm_q, fflags_q} : '0;
            default:       rdata_o = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Modify side
    //////////////////////////////////////////////////

    // Only legal writing requests touch state
    assign wen = req_i.valid && !req_i.illegal && (req_i.op != CSR_READ);

    // New value before the per-register masks
    always_comb begin
        case (req_i.op)
            CSR_WRITE: wval = req_i.wdata;
            CSR_SET:   wval = rdata_o | req_i.wdata;
            CSR_CLEAR: wval = rdata_o & ~req_i.wdata;
            default:   wval = rdata_o;
        endcase
    end

    always_comb begin
        // Hold by default
        mstatus_mie_n  = mstatus_mie_q;
        mstatus_mpie_n = mstatus_mpie_q;
        mie_n          = mie_q;
        mtvec_n        = mtvec_q;
        mepc_n         = mepc_q;
        mcause_n       = mcause_q;
        mscratch_n     = mscratch_q;
        fflags_n       = fflags_q;
        frm_n          = frm_q;

        // FPU flags accumulate, a CSR write below overrides
        if ((`CSR_ISA_F != 0) && fflags_set_i) begin
            fflags_n = fflags_q | fflags_i;
        end

        if (wen) begin
            case (req_i.addr)
                CSR_MSTATUS: begin
                    mstatus_mie_n  = wval[3];
                    mstatus_mpie_n = wval[7];
                end
                CSR_MIE:      mie_n      = wval;
                // Direct mode only
                CSR_MTVEC:    mtvec_n    = {wval[31:2], 2'b00};
                CSR_MSCRATCH: mscratch_n = wval;
                CSR_MEPC:     mepc_n     = wval & `CSR_MEPC_ALIGN_MASK;
                CSR_MCAUSE:   mcause_n   = wval[4:0];
                CSR_FFLAGS:   fflags_n   = wval[4:0];
                CSR_FRM:      frm_n      = wval[2:0];
                CSR_FCSR: begin
                    frm_n    = wval[7:5];
                    fflags_n = wval[4:0];
                end
                default: ;
            endcase
        end

        // Trap entry wins over a same-cycle write
        if (trap_i.valid) begin
            mepc_n         = trap_i.pc & `CSR_MEPC_ALIGN_MASK;
            mcause_n       = trap_i.cause;
            mstatus_mpie_n = mstatus_mie_q;
            mstatus_mie_n  = 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // State
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
            mie_q          <= '0;
            mtvec_q        <= `CSR_MTVEC_RESET;
            mepc_q         <= '0;
            mcause_q       <= '0;
            mscratch_q     <= '0;
            fflags_q       <= '0;
            frm_q          <= '0;
        end else begin
            mstatus_mie_q  <= mstatus_mie_n;
            mstatus_mpie_q <= mstatus_mpie_n;
            mie_q          <= mie_n;
            mtvec_q        <= mtvec_n;
            mepc_q         <= mepc_n;
            mcause_q       <= mcause_n;
            mscratch_q     <= mscratch_n;
            fflags_q       <= fflags_n;
            frm_q          <= frm_n;
        end
    end

    // Registered outputs
    assign mtvec_o = mtvec_q;
    assign frm_o   = frm_q;
    // Next mepc, so a return right after a write sees it
    assign mepc_o  = mepc_n;

endmodule

//--- csr_writeback.sv
//////////////////////////////////////////////////
// CSR write-back stage
// Registers the old CSR value for rd, or the
// illegal-instruction report
//////////////////////////////////////////////////

`timescale 1ns/1ps

module csr_writeback (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  csr_pkg::csr_req_t req_i,
    input  csr_pkg::xlen_t    rdata_i,
    output csr_pkg::csr_wb_t  wb_o
);

    import csr_pkg::*;

    csr_wb_t wb_q;
    csr_wb_t wb_n;

    // Result for this cycle's request
    always_comb begin
        wb_n = '0;
        if (req_i.valid) begin
            wb_n.valid = 1'b1;
            wb_n.rd    = req_i.rd;
            if (req_i.illegal) begin
                // Report only, no data to rd
                wb_n.illegal = 1'b1;
                wb_n.data    = '0;
            end else begin
                // Old value, rd x0 dropped by the core
                wb_n.illegal = 1'b0;
                wb_n.data    = rdata_i;
            end
        end
    end

    // Idle cycles clear the register, valid is a one-cycle strobe
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_q <= '0;
        end else begin
            wb_q <= wb_n;
        end
    end

    assign wb_o = wb_q;

endmodule

//--- csr_unit_top.sv
//////////////////////////////////////////////////
// CSR unit top level
// Decoder, register file and write-back stage
//////////////////////////////////////////////////

`timescale 1ns/1ps

module csr_unit_top (
    input  logic               clk_i,
    input  logic               rst_n_i,
    // Instruction strobe
    input  logic               instr_valid_i,
    input  csr_pkg::xlen_t     instr_i,
    input  csr_pkg::xlen_t     rs1_data_i,
    // Hart and trap inputs
    input  csr_pkg::xlen_t     hartid_i,
    input  csr_pkg::trap_req_t trap_i,
    // FPU flag pulses
    input  logic               fflags_set_i,
    input  logic [4:0]         fflags_i,
    // Results
    output csr_pkg::csr_wb_t   wb_o,
    output csr_pkg::xlen_t     mtvec_o,
    output csr_pkg::xlen_t     mepc_o,
    output logic [2:0]         frm_o
);

    import csr_pkg::*;

    // Decode to execute, old value to result
    csr_req_t req;
    xlen_t    rdata;

    csr_decoder u_decoder (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_data_i    (rs1_data_i),
        .req_o         (req)
    );

    csr_regfile u_regfile (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_i         (req),
        .hartid_i      (hartid_i),
        .trap_i        (trap_i),
        .fflags_set_i  (fflags_set_i),
        .fflags_i      (fflags_i),
        .rdata_o       (rdata),
        .mtvec_o       (mtvec_o),
        .mepc_o        (mepc_o),
        .frm_o         (frm_o)
    );

    csr_writeback u_writeback (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_i         (req),
        .rdata_i       (rdata),
        .wb_o          (wb_o)
    );

endmodule

//--- csr_unit_tb.sv
//////////////////////////////////////////////////
// CSR unit testbench
// Replays the case file through the DUT and checks
// write-back, mtvec_o, mepc_o and frm_o
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "csr_unit_config.svh"

module csr_unit_tb;

    import csr_pkg::*;

    localparam int    WB_TIMEOUT  = 20;
    localparam int    RAND_WRITES = 4;
    localparam xlen_t HART_ID     = 32'h0000_0003;

    // DUT ports
    logic       clk_i;
    logic       rst_n_i;
    logic       instr_valid_i;
    xlen_t      instr_i;
    xlen_t      rs1_data_i;
    xlen_t      hartid_i;
    trap_req_t  trap_i;
    logic       fflags_set_i;
    logic [4:0] fflags_i;
    csr_wb_t    wb_o;
    xlen_t      mtvec_o;
    xlen_t      mepc_o;
    logic [2:0] frm_o;

    // Case file state
    integer           fd;
    integer           code;
    integer           case_num;
    integer           seed;
    logic             done;
    logic [7:0]       kind;
    logic [8*128-1:0] skip_line;
    xlen_t            word_a;
    xlen_t            word_b;
    xlen_t            exp_valid;
    xlen_t            exp_illegal;
    xlen_t            exp_data;

    csr_unit_top DUT (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_data_i    (rs1_data_i),
        .hartid_i      (hartid_i),
        .trap_i        (trap_i),
        .fflags_set_i  (fflags_set_i),
        .fflags_i      (fflags_i),
        .wb_o          (wb_o),
        .mtvec_o       (mtvec_o),
        .mepc_o        (mepc_o),
        .frm_o         (frm_o)
    );

    // 4 ns clock
    always #2 clk_i = ~clk_i;

    //////////////////////////////////////////////////
    // Failure reporting
    //////////////////////////////////////////////////

    task automatic stop_with_fail(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string what, input xlen_t got, input xlen_t exp);
        stop_with_fail($sformatf("FAILED at %0d ns: case %0d %s is %h, expected %h",
                                 $time, case_num, what, got, exp));
    endtask

    //////////////////////////////////////////////////
    // Drivers and checks
    //////////////////////////////////////////////////

    // Poll the result strobe once per cycle
    task automatic wait_for_wb();
        int cycles;
        cycles = 0;
        while (!wb_o.valid && cycles < WB_TIMEOUT) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        if (!wb_o.valid) begin
            stop_with_fail($sformatf("Timeout: no write-back within %0d cycles in case %0d",
                                     WB_TIMEOUT, case_num));
        end
    endtask

    // One-cycle instruction strobe that returns once the result is out
    task automatic issue_instr(input xlen_t instr, input xlen_t rs1);
        instr_valid_i = 1'b1;
        instr_i       = instr;
        rs1_data_i    = rs1;
        @(posedge clk_i);
        #1;
        instr_valid_i = 1'b0;
        wait_for_wb();
    endtask

    task automatic check_wb(input logic valid, input logic illegal, input xlen_t data,
                            input reg_idx_t rd);
        assert (wb_o.valid === valid)
            else report_mismatch("wb valid", 32'(wb_o.valid), 32'(valid));
        assert (wb_o.illegal === illegal)
            else report_mismatch("wb illegal", 32'(wb_o.illegal), 32'(illegal));
        assert (wb_o.data === data)
            else report_mismatch("wb data", wb_o.data, data);
        // rd from the instruction word on a legal result
        if (!illegal) begin
            assert (wb_o.rd === rd)
                else report_mismatch("wb rd", 32'(wb_o.rd), 32'(rd));
        end
    endtask

    // No instruction in the last cycle so the result strobe is low
    task automatic check_wb_idle(input logic valid, input logic illegal);
        assert (wb_o.valid === valid)
            else report_mismatch("idle wb valid", 32'(wb_o.valid), 32'(valid));
        assert (wb_o.illegal === illegal)
            else report_mismatch("idle wb illegal", 32'(wb_o.illegal), 32'(illegal));
    endtask

    task automatic pulse_trap(input xlen_t pc, input exc_cause_t cause, input xlen_t exp_mepc);
        trap_i.valid = 1'b1;
        trap_i.pc    = pc;
        trap_i.cause = cause;
        @(posedge clk_i);
        #1;
        trap_i.valid = 1'b0;
        // Strobe gone so mepc_o shows the saved PC
        @(negedge clk_i);
        assert (mepc_o === exp_mepc)
            else report_mismatch("mepc_o", mepc_o, exp_mepc);
        @(posedge clk_i);
        #1;
    endtask

    task automatic pulse_fflags(input logic [4:0] flags);
        fflags_set_i = 1'b1;
        fflags_i     = flags;
        @(posedge clk_i);
        #1;
        fflags_set_i = 1'b0;
        fflags_i     = '0;
    endtask

    // Chain of random mscratch writes that each return the previous value
    task automatic scratch_chain(input xlen_t write_instr, input xlen_t read_instr,
                                 input xlen_t first_old);
        xlen_t prev;
        xlen_t rnd;
        prev = first_old;
        for (int k = 0; k < RAND_WRITES; k++) begin
            rnd = $random(seed);
            issue_instr(write_instr, rnd);
            check_wb(1'b1, 1'b0, prev, write_instr[11:7]);
            prev = rnd;
        end
        issue_instr(read_instr, '0);
        check_wb(1'b1, 1'b0, prev, read_instr[11:7]);
    endtask

    task automatic run_case();
        case (kind)
            "I": begin
                issue_instr(word_a, word_b);
                check_wb(exp_valid[0], exp_illegal[0], exp_data, word_a[11:7]);
            end
            "T": begin
                pulse_trap(word_a, word_b[4:0], exp_data);
                check_wb_idle(exp_valid[0], exp_illegal[0]);
            end
            "F": begin
                pulse_fflags(word_a[4:0]);
                check_wb_idle(exp_valid[0], exp_illegal[0]);
            end
            "C": begin
                assert (mtvec_o === word_a)
                    else report_mismatch("mtvec_o", mtvec_o, word_a);
                assert (frm_o === word_b[2:0])
                    else report_mismatch("frm_o", 32'(frm_o), word_b);
            end
            "R": scratch_chain(word_a, word_b, exp_data);
            default: stop_with_fail($sformatf("Unknown kind in case %0d", case_num));
        endcase
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        rs1_data_i    = '0;
        hartid_i      = HART_ID;
        trap_i        = '0;
        fflags_set_i  = 1'b0;
        fflags_i      = '0;
        seed          = 32'hc5bae621;
        case_num      = 0;
        done          = 1'b0;

        fd = $fopen("csr_unit_cases.txt", "r");
        if (fd == 0) begin
            stop_with_fail("Could not open the case file csr_unit_cases.txt");
        end

        repeat (3) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        assert (mtvec_o === `CSR_MTVEC_RESET)
            else report_mismatch("mtvec_o after reset", mtvec_o, `CSR_MTVEC_RESET);
        check_wb_idle(1'b0, 1'b0);

        while (!done) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                code = $fgets(skip_line, fd);
            end else begin
                code = $fscanf(fd, " %h %h %h %h %h",
                               word_a, word_b, exp_valid, exp_illegal, exp_data);
                if (code != 5) begin
                    stop_with_fail($sformatf("Malformed line after case %0d", case_num));
                end
                case_num++;
                run_case();
            end
        end
        $fclose(fd);

        if (case_num == 0) begin
            stop_with_fail("The case file held no cases");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

//--- csr_unit_cases.txt
# kind a b valid illegal data; I: instr, rs1 value  T: pc, cause, data = mepc_o
# F: fflags  C: mtvec_o, frm_o  R: write instr, read instr, data = old mscratch
I 30502573 00000000 1 0 00000100
I F1402573 00000000 1 0 00000003
I 30102573 00000000 1 0 40001124
I 30002573 00000000 1 0 00001800
I 34029573 12345678 1 0 00000000
I 3402A573 0000F000 1 0 12345678
I 3402B573 00000078 1 0 1234F678
I 34002573 00000000 1 0 1234F600
I 304FD573 00000000 1 0 00000000
I 3042F573 00000000 1 0 0000001F
I 30426573 00000000 1 0 0000001A
I 30429573 00000888 1 0 0000001E
I 30402573 00000000 1 0 00000888
I 30529573 80000003 1 0 00000100
C 80000000 00000000 0 0 00000000
I 34129573 00001237 1 0 00000000
I 34102573 00000000 1 0 00001236
I 34229573 FFFFFFFF 1 0 00000000
I 34202573 00000000 1 0 0000001F
I 30029573 FFFFFFFF 1 0 00001800
I 30002573 00000000 1 0 00001888
I F1129573 00000055 1 1 00000000
I 7C029573 00000055 1 1 00000000
I 3402C573 DEADBEEF 1 1 00000000
I 34002573 00000000 1 0 1234F600
T 00002005 0000000B 0 0 00002004
I 34102573 00000000 1 0 00002004
I 34202573 00000000 1 0 0000000B
I 30002573 00000000 1 0 00001880
F 00000001 00000000 0 0 00000000
F 00000004 00000000 0 0 00000000
I 00102573 00000000 1 0 00000005
I 0021D573 00000000 1 0 00000000
C 80000000 00000003 0 0 00000000
I 00329573 000000FF 1 0 00000065
C 80000000 00000007 0 0 00000000
R 34029573 34002573 0 0 1234F600

//--- csr_unit.f
+incdir+.
csr_pkg.sv
csr_decoder.sv
csr_regfile.sv
csr_writeback.sv
csr_unit_top.sv
csr_unit_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = csr_unit_tb
FILELIST  = csr_unit.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
